// ==== Makefile ====
# Verilator build and run for the 3x3 convolution engine

VERILATOR ?= verilator
TOP       ?= tb_conv_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= ALL CHECKS PASSED

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
src/conv_pkg.sv
src/conv_line_buffer.sv
src/conv_weight_regs.sv
src/conv_pe_row.sv
src/conv_accum.sv
src/conv_top.sv
verif/tb_clk_gen.sv
verif/tb_conv_top.sv

// ==== src/conv_accum.sv ====
`default_nettype none
`timescale 1ns/1ps

module conv_accum (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              win_valid,
    input  conv_pkg::psum_t   row_sum0,
    input  conv_pkg::psum_t   row_sum1,
    input  conv_pkg::psum_t   row_sum2,
    output logic              ofmap_valid,
    output conv_pkg::ofmap_t  ofmap_out
);

    // win_valid delayed to line up with the PE row registers
    logic            sum_valid;
    conv_pkg::ofmap_t total;

    assign total = conv_pkg::ofmap_t'(row_sum0)
                 + conv_pkg::ofmap_t'(row_sum1)
                 + conv_pkg::ofmap_t'(row_sum2);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_valid   <= 1'b0;
            ofmap_valid <= 1'b0;
        end else begin
            sum_valid   <= win_valid;
            ofmap_valid <= sum_valid;
        end
    end

    // output holds between windows
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ofmap_out <= '0;
        end else if (sum_valid) begin
            ofmap_out <= total;
        end
    end

endmodule

`default_nettype wire

// ==== src/conv_line_buffer.sv ====
`default_nettype none
`timescale 1ns/1ps

module conv_line_buffer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pixel_valid,
    input  logic                  frame_start,
    input  conv_pkg::pixel_t      pixel_in,
    output conv_pkg::pixel_row_t  win_row0,
    output conv_pkg::pixel_row_t  win_row1,
    output conv_pkg::pixel_row_t  win_row2,
    output logic                  win_valid
);

    // one spare bit so an overrun of the column count is visible
    typedef logic [$clog2(conv_pkg::ROW_LEN+1)-1:0] col_t;

    // chain[0] is the newest pixel, two full rows plus three behind it
    conv_pkg::pixel_t [2*conv_pkg::ROW_LEN+2:0] chain;

    col_t       col_cnt;
    logic [1:0] row_cnt;
    col_t       pos_col;
    logic [1:0] pos_row;

    // position of the pixel on pixel_in
    assign pos_col = frame_start ? '0 : col_cnt;
    assign pos_row = frame_start ? 2'd0 : row_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            chain <= '0;
        end else if (pixel_valid) begin
            chain <= {chain[2*conv_pkg::ROW_LEN+1:0], pixel_in};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_cnt   <= '0;
            row_cnt   <= 2'd0;
            win_valid <= 1'b0;
        end else begin
            // full window once at least 3 rows and 3 columns are in
            win_valid <= pixel_valid && (pos_row == 2'd2) && (pos_col >= col_t'(2));
            if (pixel_valid) begin
                if (pos_col == col_t'(conv_pkg::ROW_LEN - 1)) begin
                    col_cnt <= '0;
                    // row count only needs to tell rows 0, 1 and the rest apart
                    if (pos_row == 2'd2) begin
                        row_cnt <= pos_row;
                    end else begin
                        row_cnt <= pos_row + 2'd1;
                    end
                end else begin
                    col_cnt <= pos_col + col_t'(1);
                    row_cnt <= pos_row;
                end
            end
        end
    end

    // window taps, top row is two rows back in the chain
    assign win_row0 = {chain[2*conv_pkg::ROW_LEN],
                       chain[2*conv_pkg::ROW_LEN+1],
                       chain[2*conv_pkg::ROW_LEN+2]};
    assign win_row1 = {chain[conv_pkg::ROW_LEN],
                       chain[conv_pkg::ROW_LEN+1],
                       chain[conv_pkg::ROW_LEN+2]};
    assign win_row2 = {chain[0], chain[1], chain[2]};

    a_col_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        col_cnt < col_t'(conv_pkg::ROW_LEN)
    ) else $error("column counter reached ROW_LEN");

endmodule

`default_nettype wire

// ==== src/conv_pe_row.sv ====
`default_nettype none
`timescale 1ns/1ps

module conv_pe_row (
    input  logic                   clk,
    input  logic                   rst_n,
    input  conv_pkg::pixel_row_t   win_row,
    input  conv_pkg::weight_row_t  kernel_row,
    output conv_pkg::psum_t        row_sum
);

    logic signed [conv_pkg::PIXEL_W+conv_pkg::WEIGHT_W-1:0] prod [conv_pkg::KERNEL_DIM];
    conv_pkg::psum_t dot;

    // one signed multiplier per kernel column
    always_comb begin
        for (int k = 0; k < conv_pkg::KERNEL_DIM; k++) begin
            prod[k] = $signed(win_row[k]) * $signed(kernel_row[k]);
        end
    end

    assign dot = conv_pkg::psum_t'(prod[0])
               + conv_pkg::psum_t'(prod[1])
               + conv_pkg::psum_t'(prod[2]);

    // free running, alignment is tracked downstream
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_sum <= '0;
        end else begin
            row_sum <= dot;
        end
    end

endmodule

`default_nettype wire

// ==== src/conv_pkg.sv ====
`default_nettype none

package conv_pkg;

    // feature-map geometry
    localparam int ROW_LEN    = 16;
    localparam int KERNEL_DIM = 3;

    // datapath widths
    localparam int PIXEL_W  = 8;
    localparam int WEIGHT_W = 8;
    localparam int PSUM_W   = 18;
    localparam int OFMAP_W  = 20;

    typedef logic signed [PIXEL_W-1:0]  pixel_t;
    typedef logic signed [WEIGHT_W-1:0] weight_t;

    // index 0 is the leftmost, oldest column
    typedef pixel_t  [KERNEL_DIM-1:0] pixel_row_t;
    typedef weight_t [KERNEL_DIM-1:0] weight_row_t;

    typedef logic signed [PSUM_W-1:0]  psum_t;
    typedef logic signed [OFMAP_W-1:0] ofmap_t;

endpackage

`default_nettype wire

// ==== src/conv_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module conv_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              pixel_valid,
    input  logic              frame_start,
    input  logic              weight_en,
    input  conv_pkg::pixel_t  pixel_in,
    input  conv_pkg::weight_t weight_in0,
    input  conv_pkg::weight_t weight_in1,
    input  conv_pkg::weight_t weight_in2,
    input  conv_pkg::weight_t weight_in3,
    input  conv_pkg::weight_t weight_in4,
    input  conv_pkg::weight_t weight_in5,
    input  conv_pkg::weight_t weight_in6,
    input  conv_pkg::weight_t weight_in7,
    input  conv_pkg::weight_t weight_in8,
    output logic              ofmap_valid,
    output conv_pkg::ofmap_t  ofmap_out
);

    conv_pkg::pixel_row_t  win_row0;
    conv_pkg::pixel_row_t  win_row1;
    conv_pkg::pixel_row_t  win_row2;
    logic                  win_valid;

    conv_pkg::weight_row_t kernel_row0;
    conv_pkg::weight_row_t kernel_row1;
    conv_pkg::weight_row_t kernel_row2;

    conv_pkg::psum_t       row_sum0;
    conv_pkg::psum_t       row_sum1;
    conv_pkg::psum_t       row_sum2;

    conv_line_buffer i_line_buffer (
        .clk         (clk),
        .rst_n       (rst_n),
        .pixel_valid (pixel_valid),
        .frame_start (frame_start),
        .pixel_in    (pixel_in),
        .win_row0    (win_row0),
        .win_row1    (win_row1),
        .win_row2    (win_row2),
        .win_valid   (win_valid)
    );

    conv_weight_regs i_weight_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .weight_en   (weight_en),
        .weight_in0  (weight_in0),
        .weight_in1  (weight_in1),
        .weight_in2  (weight_in2),
        .weight_in3  (weight_in3),
        .weight_in4  (weight_in4),
        .weight_in5  (weight_in5),
        .weight_in6  (weight_in6),
        .weight_in7  (weight_in7),
        .weight_in8  (weight_in8),
        .pixel_valid (pixel_valid),
        .kernel_row0 (kernel_row0),
        .kernel_row1 (kernel_row1),
        .kernel_row2 (kernel_row2)
    );

    // one PE row per kernel row, top row first
    conv_pe_row i_pe_row0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .win_row    (win_row0),
        .kernel_row (kernel_row0),
        .row_sum    (row_sum0)
    );

    conv_pe_row i_pe_row1 (
        .clk        (clk),
        .rst_n      (rst_n),
        .win_row    (win_row1),
        .kernel_row (kernel_row1),
        .row_sum    (row_sum1)
    );

    conv_pe_row i_pe_row2 (
        .clk        (clk),
        .rst_n      (rst_n),
        .win_row    (win_row2),
        .kernel_row (kernel_row2),
        .row_sum    (row_sum2)
    );

    conv_accum i_accum (
        .clk         (clk),
        .rst_n       (rst_n),
        .win_valid   (win_valid),
        .row_sum0    (row_sum0),
        .row_sum1    (row_sum1),
        .row_sum2    (row_sum2),
        .ofmap_valid (ofmap_valid),
        .ofmap_out   (ofmap_out)
    );

endmodule

`default_nettype wire

// ==== src/conv_weight_regs.sv ====
`default_nettype none
`timescale 1ns/1ps

module conv_weight_regs (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   weight_en,
    input  conv_pkg::weight_t      weight_in0,
    input  conv_pkg::weight_t      weight_in1,
    input  conv_pkg::weight_t      weight_in2,
    input  conv_pkg::weight_t      weight_in3,
    input  conv_pkg::weight_t      weight_in4,
    input  conv_pkg::weight_t      weight_in5,
    input  conv_pkg::weight_t      weight_in6,
    input  conv_pkg::weight_t      weight_in7,
    input  conv_pkg::weight_t      weight_in8,
    input  logic                   pixel_valid,
    output conv_pkg::weight_row_t  kernel_row0,
    output conv_pkg::weight_row_t  kernel_row1,
    output conv_pkg::weight_row_t  kernel_row2
);

    // raster kernel order, leftmost weight at index 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            kernel_row0 <= '0;
            kernel_row1 <= '0;
            kernel_row2 <= '0;
        end else if (weight_en) begin
            kernel_row0 <= {weight_in2, weight_in1, weight_in0};
            kernel_row1 <= {weight_in5, weight_in4, weight_in3};
            kernel_row2 <= {weight_in8, weight_in7, weight_in6};
        end
    end

    // a load in a push cycle would split a window between two kernels
    a_no_load_during_push: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(weight_en && pixel_valid)
    ) else $error("weight_en and pixel_valid high in the same cycle");

endmodule

`default_nettype wire

// ==== verif/tb_clk_gen.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    // 4 ns period
    localparam int HALF_PERIOD_NS = 2;
    localparam int RST_CYCLES     = 16;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

    // release on a falling edge, clear of the stimulus slot
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verif/tb_conv_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_conv_top;

    localparam int ROW_LEN = conv_pkg::ROW_LEN;
    // full rows of all frames plus the partial frame cut by the restart
    localparam int TOTAL_PIXELS    = ROW_LEN * (6 + 4 + 6 + 6 + 5) + 2 * ROW_LEN + 7;
    localparam int WATCHDOG_CYCLES = TOTAL_PIXELS * 8 + 200;

    logic              clk;
    logic              rst_n;
    logic              pixel_valid;
    logic              frame_start;
    logic              weight_en;
    conv_pkg::pixel_t  pixel_in;
    conv_pkg::weight_t w_in [9];
    logic              ofmap_valid;
    conv_pkg::ofmap_t  ofmap_out;

    // reference model keeps pixels by row modulo 3
    int model_w [9];
    int model_pix [3][ROW_LEN];
    int m_row;
    int m_col;
    int exp_q [$];
    int due_q [$];

    int cycle;
    int n_checks;
    int n_errors;

    tb_clk_gen i_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    conv_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .pixel_valid (pixel_valid),
        .frame_start (frame_start),
        .weight_en   (weight_en),
        .pixel_in    (pixel_in),
        .weight_in0  (w_in[0]),
        .weight_in1  (w_in[1]),
        .weight_in2  (w_in[2]),
        .weight_in3  (w_in[3]),
        .weight_in4  (w_in[4]),
        .weight_in5  (w_in[5]),
        .weight_in6  (w_in[6]),
        .weight_in7  (w_in[7]),
        .weight_in8  (w_in[8]),
        .ofmap_valid (ofmap_valid),
        .ofmap_out   (ofmap_out)
    );

    // mode 0 full range with extra extremes, mode 1 extremes only, mode 2 fixed -128
    function automatic conv_pkg::pixel_t pick_value(input int mode);
        logic [31:0] r;
        r = $urandom;
        if (mode == 2) begin
            return 8'h80;
        end else if (mode == 1) begin
            return r[0] ? 8'h7f : 8'h80;
        end
        case (r[10:8])
            3'd0:    return 8'h80;
            3'd1:    return 8'h7f;
            default: return r[7:0];
        endcase
    endfunction

    task automatic check_output();
        if (due_q.size() > 0 && due_q[0] == cycle) begin
            n_checks++;
            if (ofmap_valid !== 1'b1) begin
                $display("%0t: no ofmap_valid in cycle %0d, a window result was due",
                         $time, cycle);
                n_errors++;
            end else if (int'(ofmap_out) != exp_q[0]) begin
                $display("CHECK FAILED at %0t: ofmap_out %0d, expected %0d",
                         $time, ofmap_out, exp_q[0]);
                n_errors++;
            end
            void'(due_q.pop_front());
            void'(exp_q.pop_front());
        end else if (ofmap_valid !== 1'b0) begin
            $display("%0t: ofmap_valid high in cycle %0d with no window due", $time, cycle);
            n_errors++;
        end
    endtask

    // outputs are settled 1 ns after the edge and inputs change right after the check
    task automatic next_cycle();
        @(posedge clk);
        cycle++;
        #1;
        check_output();
    endtask

    task automatic model_push(input int pix, input logic fs);
        int acc;
        if (fs) begin
            m_row = 0;
            m_col = 0;
        end
        model_pix[m_row % 3][m_col] = pix;
        if (m_row >= 2 && m_col >= 2) begin
            acc = 0;
            for (int i = 0; i < 3; i++) begin
                for (int j = 0; j < 3; j++) begin
                    acc += model_pix[(m_row - 2 + i) % 3][m_col - 2 + j] * model_w[3 * i + j];
                end
            end
            exp_q.push_back(acc);
            due_q.push_back(cycle + 3);
        end
        if (m_col == ROW_LEN - 1) begin
            m_col = 0;
            m_row++;
        end else begin
            m_col++;
        end
    endtask

    task automatic push_pixel(input conv_pkg::pixel_t pix, input logic fs);
        next_cycle();
        pixel_valid = 1'b1;
        frame_start = fs;
        weight_en   = 1'b0;
        pixel_in    = pix;
        model_push(int'(pix), fs);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            next_cycle();
            pixel_valid = 1'b0;
            frame_start = 1'b0;
            weight_en   = 1'b0;
            // junk on the bus while idle
            pixel_in    = pick_value(0);
        end
    endtask

    task automatic load_weights(input int mode);
        next_cycle();
        pixel_valid = 1'b0;
        frame_start = 1'b0;
        weight_en   = 1'b1;
        for (int k = 0; k < 9; k++) begin
            w_in[k]    = pick_value(mode);
            model_w[k] = int'(w_in[k]);
        end
    endtask

    task automatic stream_pixels(input int count, input bit with_gaps, input int mode,
                                 input bit new_frame);
        logic [31:0] r;
        for (int p = 0; p < count; p++) begin
            push_pixel(pick_value(mode), new_frame && (p == 0));
            if (with_gaps) begin
                r = $urandom;
                if (r[0]) begin
                    idle_cycles(int'(r[2:1]) + 1);
                end
            end
        end
    endtask

    initial begin
        pixel_valid = 1'b0;
        frame_start = 1'b0;
        weight_en   = 1'b0;
        pixel_in    = '0;
        for (int k = 0; k < 9; k++) begin
            w_in[k]    = '0;
            model_w[k] = 0;
        end
        cycle    = 0;
        n_checks = 0;
        n_errors = 0;
        m_row    = 0;
        m_col    = 0;
        void'($urandom(32'hb856));

        // nothing may come out during or right after reset
        while (rst_n !== 1'b1) begin
            next_cycle();
        end
        idle_cycles(5);

        // dense random frame
        load_weights(0);
        stream_pixels(6 * ROW_LEN, 1'b0, 0, 1'b1);
        idle_cycles(4);

        // largest magnitude sums and then random extremes
        load_weights(2);
        stream_pixels(3 * ROW_LEN, 1'b0, 2, 1'b1);
        load_weights(1);
        stream_pixels(ROW_LEN, 1'b0, 1, 1'b0);
        idle_cycles(4);

        // random gaps between pushes
        load_weights(0);
        stream_pixels(6 * ROW_LEN, 1'b1, 0, 1'b1);

        // kernel swap half way through a row
        stream_pixels(3 * ROW_LEN + ROW_LEN / 2, 1'b1, 0, 1'b1);
        idle_cycles(2);
        load_weights(0);
        idle_cycles(1);
        stream_pixels(2 * ROW_LEN + ROW_LEN / 2, 1'b0, 0, 1'b0);

        // new frame starting in mid-row
        stream_pixels(2 * ROW_LEN + 7, 1'b0, 0, 1'b1);
        stream_pixels(5 * ROW_LEN, 1'b0, 0, 1'b1);

        idle_cycles(8);
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run still going after %0d cycles", WATCHDOG_CYCLES);
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
